/* verilog/aes_params.svh */
// AES-128 core constants, shared by the package and the RTL modules.
// Include wherever a width or round constant is needed.

`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// round count for a 128-bit key
`define AES_NUM_ROUNDS 10

`define AES_BLOCK_BITS 128
`define AES_WORD_BITS 32
`define AES_BYTE_BITS 8

`define AES_RCON_INIT 8'h01    // rcon of the first round
`define AES_RCON_POLY 8'h1b    // x^8 reduction for GF(2^8) doubling

`endif

/* verilog/aes_pkg.sv */
// Shared types of the iterative AES-128 core.
// Referenced with scoped names, aes_pkg::block_t and so on.

`include "aes_params.svh"

package aes_pkg;

    typedef logic [`AES_BLOCK_BITS-1:0] block_t;  // state or round key
    typedef logic [`AES_WORD_BITS-1:0]  word_t;   // one column
    typedef logic [`AES_BYTE_BITS-1:0]  byte_t;

    // wide enough to hold the last round number
    typedef logic [$clog2(`AES_NUM_ROUNDS + 1)-1:0] round_t;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,        // waiting for in_req
        RUN,         // one round per clock
        OUT_HOLD,    // out_req high, waiting for out_ack
        OUT_RELEASE  // waiting for out_ack to drop
    } ctrl_state_t;

endpackage

/* verilog/aes_sbox.sv */
// AES forward S-box for one byte, as a gate network.
// Linear top layer, shared GF(2^4) inversion in the middle, and a linear
// bottom layer that also folds in the affine constant 0x63.
// Purely combinational; used by the round and by the key step.

`timescale 1ns/1ps

module aes_sbox (
    input  aes_pkg::byte_t in_byte,
    output aes_pkg::byte_t out_byte
);

    logic [0:7]  x;   // x[0] is the byte msb
    logic [0:7]  s;
    logic [21:1] y;
    logic [67:0] t;
    logic [17:0] z;

    assign x        = in_byte;
    assign out_byte = s;

    always_comb
    begin
        ////////////////////////////////////////
        // top linear layer
        y[14] = x[3] ^ x[5];
        y[13] = x[0] ^ x[6];
        y[9]  = x[0] ^ x[3];
        y[8]  = x[0] ^ x[5];
        t[0]  = x[1] ^ x[2];
        y[1]  = t[0] ^ x[7];
        y[4]  = y[1] ^ x[3];
        y[12] = y[13] ^ y[14];
        y[2]  = y[1] ^ x[0];
        y[5]  = y[1] ^ x[6];
        y[3]  = y[5] ^ y[8];
        t[1]  = x[4] ^ y[12];
        y[15] = t[1] ^ x[5];
        y[20] = t[1] ^ x[1];
        y[6]  = y[15] ^ x[7];
        y[10] = y[15] ^ t[0];
        y[11] = y[20] ^ y[9];
        y[7]  = x[7] ^ y[11];
        y[17] = y[10] ^ y[11];
        y[19] = y[10] ^ y[8];
        y[16] = t[0] ^ y[11];
        y[21] = y[13] ^ y[16];
        y[18] = x[0] ^ y[16];

        ////////////////////////////////////////
        // nonlinear middle with the GF(2^4) inversion
        t[2]  = y[12] & y[15];
        t[3]  = y[3] & y[6];
        t[4]  = t[3] ^ t[2];
        t[5]  = y[4] & x[7];
        t[6]  = t[5] ^ t[2];
        t[7]  = y[13] & y[16];
        t[8]  = y[5] & y[1];
        t[9]  = t[8] ^ t[7];
        t[10] = y[2] & y[7];
        t[11] = t[10] ^ t[7];
        t[12] = y[9] & y[11];
        t[13] = y[14] & y[17];
        t[14] = t[13] ^ t[12];
        t[15] = y[8] & y[10];
        t[16] = t[15] ^ t[12];
        t[17] = t[4] ^ t[14];
        t[18] = t[6] ^ t[16];
        t[19] = t[9] ^ t[14];
        t[20] = t[11] ^ t[16];
        t[21] = t[17] ^ y[20];
        t[22] = t[18] ^ y[19];
        t[23] = t[19] ^ y[21];
        t[24] = t[20] ^ y[18];
        t[25] = t[21] ^ t[22];
        t[26] = t[21] & t[23];
        t[27] = t[24] ^ t[26];
        t[28] = t[25] & t[27];
        t[29] = t[28] ^ t[22];
        t[30] = t[23] ^ t[24];
        t[31] = t[22] ^ t[26];
        t[32] = t[31] & t[30];
        t[33] = t[32] ^ t[24];
        t[34] = t[23] ^ t[33];
        t[35] = t[27] ^ t[33];
        t[36] = t[24] & t[35];
        t[37] = t[36] ^ t[34];
        t[38] = t[27] ^ t[36];
        t[39] = t[29] & t[38];
        t[40] = t[25] ^ t[39];
        t[41] = t[40] ^ t[37];
        t[42] = t[29] ^ t[33];
        t[43] = t[29] ^ t[40];
        t[44] = t[33] ^ t[37];
        t[45] = t[42] ^ t[41];

        // products with the top layer
        z[0]  = t[44] & y[15];
        z[1]  = t[37] & y[6];
        z[2]  = t[33] & x[7];
        z[3]  = t[43] & y[16];
        z[4]  = t[40] & y[1];
        z[5]  = t[29] & y[7];
        z[6]  = t[42] & y[11];
        z[7]  = t[45] & y[17];
        z[8]  = t[41] & y[10];
        z[9]  = t[44] & y[12];
        z[10] = t[37] & y[3];
        z[11] = t[33] & y[4];
        z[12] = t[43] & y[13];
        z[13] = t[40] & y[5];
        z[14] = t[29] & y[2];
        z[15] = t[42] & y[9];
        z[16] = t[45] & y[14];
        z[17] = t[41] & y[8];

        ////////////////////////////////////////
        // bottom linear layer
        t[46] = z[15] ^ z[16];
        t[47] = z[10] ^ z[11];
        t[48] = z[5] ^ z[13];
        t[49] = z[9] ^ z[10];
        t[50] = z[2] ^ z[12];
        t[51] = z[2] ^ z[5];
        t[52] = z[7] ^ z[8];
        t[53] = z[0] ^ z[3];
        t[54] = z[6] ^ z[7];
        t[55] = z[16] ^ z[17];
        t[56] = z[12] ^ t[48];
        t[57] = t[50] ^ t[53];
        t[58] = z[4] ^ t[46];
        t[59] = z[3] ^ t[54];
        t[60] = t[46] ^ t[57];
        t[61] = z[14] ^ t[57];
        t[62] = t[52] ^ t[58];
        t[63] = t[49] ^ t[58];
        t[64] = z[4] ^ t[59];
        t[65] = t[61] ^ t[62];
        t[66] = z[1] ^ t[63];
        t[67] = t[64] ^ t[65];

        // inversions carry the affine constant
        s[0] = t[59] ^ t[63];
        s[3] = t[53] ^ t[66];
        s[4] = t[51] ^ t[66];
        s[5] = t[47] ^ t[65];
        s[6] = ~t[56] ^ t[62];
        s[7] = ~t[48] ^ t[60];
        s[1] = ~t[64] ^ s[3];
        s[2] = ~t[55] ^ t[67];
    end

endmodule

/* verilog/aes_key_step.sv */
// One step of AES-128 key expansion.
// Takes the previous round key and the round constant, returns the next
// round key. Combinational, evaluated once per round.

`timescale 1ns/1ps
`include "aes_params.svh"

module aes_key_step (
    input  aes_pkg::block_t key_prev,
    input  aes_pkg::byte_t  rcon,
    output aes_pkg::block_t key_next
);

    localparam int WB = `AES_WORD_BITS;
    localparam int BB = `AES_BYTE_BITS;

    aes_pkg::word_t w0, w1, w2, w3;
    aes_pkg::word_t rot_w;
    aes_pkg::word_t sub_w;
    aes_pkg::word_t mix_w;

    assign {w0, w1, w2, w3} = key_prev;

    assign rot_w = {w3[WB-BB-1:0], w3[WB-1:WB-BB]};  // RotWord, one byte left

    // SubWord
    for (genvar gi = 0; gi < WB / BB; gi++)
    begin : g_sub
        aes_sbox i_sbox (
            .in_byte  (rot_w[WB-1-BB*gi -: BB]),
            .out_byte (sub_w[WB-1-BB*gi -: BB])
        );
    end

    assign mix_w = sub_w ^ {rcon, {(WB-BB){1'b0}}};  // rcon lands on the top byte

    // each word chains off the one before it
    always_comb
    begin
        key_next[4*WB-1:3*WB] = w0 ^ mix_w;
        key_next[3*WB-1:2*WB] = w1 ^ key_next[4*WB-1:3*WB];
        key_next[2*WB-1:WB]   = w2 ^ key_next[3*WB-1:2*WB];
        key_next[WB-1:0]      = w3 ^ key_next[2*WB-1:WB];
    end

endmodule

/* verilog/aes_round.sv */
// One AES encryption round, combinational.
// SubBytes and ShiftRows always; MixColumns unless final_round is set;
// then AddRoundKey. MixColumns is built from the S-box byte, its double
// and their sum, so no general multiplier is needed.

`timescale 1ns/1ps
`include "aes_params.svh"

module aes_round (
    input  aes_pkg::block_t state,
    input  aes_pkg::block_t round_key,
    input  logic            final_round,
    output aes_pkg::block_t round_next
);

    localparam int BB = `AES_BYTE_BITS;
    localparam int NB = `AES_BLOCK_BITS / `AES_BYTE_BITS;  // 16 bytes
    localparam int CB = `AES_WORD_BITS;                    // column width

    aes_pkg::byte_t  sub_b [NB];  // S-box out, byte 0 is the state msb
    aes_pkg::byte_t  dbl_b [NB];  // S-box out times 2
    aes_pkg::block_t mixed;

    ////////////////////////////////////////
    // SubBytes and the doubled copy
    for (genvar gi = 0; gi < NB; gi++)
    begin : g_byte
        aes_sbox i_sbox (
            .in_byte  (state[`AES_BLOCK_BITS-1-BB*gi -: BB]),
            .out_byte (sub_b[gi])
        );

        assign dbl_b[gi] = {sub_b[gi][BB-2:0], 1'b0} ^
                           (sub_b[gi][BB-1] ? `AES_RCON_POLY : 8'h00);
    end

    ////////////////////////////////////////
    // ShiftRows then MixColumns, per column
    always_comb
    begin
        aes_pkg::byte_t a   [4];
        aes_pkg::byte_t a2  [4];
        aes_pkg::byte_t m   [4];
        int             src;

        mixed = '0;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                src   = 4 * ((c + r) % 4) + r;  // row r rotates left by r
                a[r]  = sub_b[src];
                a2[r] = dbl_b[src];
            end

            if (final_round)
            begin
                m = a;
            end
            else
            begin
                // 3a is 2a ^ a
                m[0] = a2[0] ^ (a2[1] ^ a[1]) ^ a[2] ^ a[3];
                m[1] = a[0] ^ a2[1] ^ (a2[2] ^ a[2]) ^ a[3];
                m[2] = a[0] ^ a[1] ^ a2[2] ^ (a2[3] ^ a[3]);
                m[3] = (a2[0] ^ a[0]) ^ a[1] ^ a[2] ^ a2[3];
            end

            for (int r = 0; r < 4; r++)
            begin
                mixed[`AES_BLOCK_BITS-1-CB*c-BB*r -: BB] = m[r];
            end
        end
    end

    assign round_next = mixed ^ round_key;  // AddRoundKey

endmodule

/* verilog/aes_iter_ctrl.sv */
// Controller of the iterative AES-128 core.
// Owns the four-phase input and output handshakes, the state and key
// registers, the round counter and the round constant. The round and key
// step logic outside is evaluated on these registers once per clock.

`timescale 1ns/1ps
`include "aes_params.svh"

module aes_iter_ctrl (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_req,
    output logic            in_ack,
    input  aes_pkg::block_t in_block,
    input  aes_pkg::block_t in_key,
    output logic            out_req,
    input  logic            out_ack,
    output aes_pkg::block_t out_block,
    output aes_pkg::block_t state,
    output aes_pkg::block_t round_key_prev,
    output aes_pkg::byte_t  rcon,
    output logic            final_round,
    input  aes_pkg::block_t round_next,
    input  aes_pkg::block_t round_key
);

    localparam aes_pkg::round_t LAST_ROUND = aes_pkg::round_t'(`AES_NUM_ROUNDS);

    aes_pkg::ctrl_state_t fsm;
    aes_pkg::round_t      round_cnt;
    aes_pkg::byte_t       rcon_dbl;

    assign final_round = (round_cnt == LAST_ROUND);
    assign out_block   = state;  // held through OUT_HOLD

    // next rcon, doubled in GF(2^8)
    assign rcon_dbl = {rcon[`AES_BYTE_BITS-2:0], 1'b0} ^
                      (rcon[`AES_BYTE_BITS-1] ? `AES_RCON_POLY : 8'h00);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fsm            <= aes_pkg::IDLE;
            in_ack         <= 1'b0;
            out_req        <= 1'b0;
            state          <= '0;
            round_key_prev <= '0;
            rcon           <= '0;
            round_cnt      <= '0;
        end
        else
        begin
            // ack release runs on its own, whatever the FSM does
            if (in_ack && !in_req)
            begin
                in_ack <= 1'b0;
            end

            case (fsm)
                aes_pkg::IDLE:
                begin
                    if (in_req && !in_ack)
                    begin
                        state          <= in_block ^ in_key;  // initial AddRoundKey
                        round_key_prev <= in_key;
                        rcon           <= `AES_RCON_INIT;
                        round_cnt      <= aes_pkg::round_t'(1);
                        in_ack         <= 1'b1;
                        fsm            <= aes_pkg::RUN;
                    end
                end

                aes_pkg::RUN:
                begin
                    state          <= round_next;
                    round_key_prev <= round_key;
                    rcon           <= rcon_dbl;
                    if (final_round)
                    begin
                        round_cnt <= '0;
                        out_req   <= 1'b1;
                        fsm       <= aes_pkg::OUT_HOLD;
                    end
                    else
                    begin
                        round_cnt <= round_cnt + aes_pkg::round_t'(1);
                    end
                end

                aes_pkg::OUT_HOLD:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        fsm     <= aes_pkg::OUT_RELEASE;
                    end
                end

                aes_pkg::OUT_RELEASE:
                begin
                    if (!out_ack)  // consumer finished its half
                    begin
                        fsm <= aes_pkg::IDLE;
                    end
                end

                default: fsm <= aes_pkg::IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // assertions

    // in_ack only answers a request seen on the previous edge
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req));

    // result must not move while offered to the consumer
    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (out_req && $past(out_req)) |-> $stable(out_block));

    a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
        round_cnt <= LAST_ROUND);

endmodule

/* verilog/aes_encrypt.sv */
// Iterative AES-128 encryption core, top level.
// Plaintext and key come in on a four-phase req/ack handshake, the
// ciphertext leaves on another. One round per clock, one block at a time;
// out_req rises ten edges after in_ack.

`timescale 1ns/1ps

module aes_encrypt (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_req,
    output logic            in_ack,
    input  aes_pkg::block_t in_block,
    input  aes_pkg::block_t in_key,
    output logic            out_req,
    input  logic            out_ack,
    output aes_pkg::block_t out_block
);

    aes_pkg::block_t state;
    aes_pkg::block_t round_key_prev;
    aes_pkg::block_t round_key;     // key of the round being computed
    aes_pkg::block_t round_next;
    aes_pkg::byte_t  rcon;
    logic            final_round;

    aes_iter_ctrl i_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_req         (in_req),
        .in_ack         (in_ack),
        .in_block       (in_block),
        .in_key         (in_key),
        .out_req        (out_req),
        .out_ack        (out_ack),
        .out_block      (out_block),
        .state          (state),
        .round_key_prev (round_key_prev),
        .rcon           (rcon),
        .final_round    (final_round),
        .round_next     (round_next),
        .round_key      (round_key)
    );

    aes_key_step i_key_step (
        .key_prev (round_key_prev),
        .rcon     (rcon),
        .key_next (round_key)
    );

    aes_round i_round (
        .state       (state),
        .round_key   (round_key),
        .final_round (final_round),
        .round_next  (round_next)
    );

endmodule

/* bench/tb_aes_encrypt.sv */
// Directed testbench for the iterative AES-128 core.
// Drives both four-phase handshakes, checks FIPS-197 known answers, the
// fixed in_ack to out_req latency, output back-pressure and input hold-off.
// Inputs change on the rising edge; outputs are sampled on the falling edge.

`timescale 1ns/1ps

module tb_aes_encrypt;

    localparam int SEED         = 29875;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 10;   // edges from in_ack rise to out_req rise
    localparam int NUM_BLOCKS   = 11;   // blocks sent over all tests
    localparam int BLOCK_CYCLES = 60;   // one block with every delay at its maximum
    localparam int TIMEOUT_CYCLES = 3 * (RESET_CYCLES + NUM_BLOCKS * BLOCK_CYCLES);

    // FIPS-197 known-answer vectors
    localparam aes_pkg::block_t KAT_KEY [3] = '{
        128'h000102030405060708090a0b0c0d0e0f,
        128'h2b7e151628aed2a6abf7158809cf4f3c,
        128'h00000000000000000000000000000000
    };
    localparam aes_pkg::block_t KAT_PT [3] = '{
        128'h00112233445566778899aabbccddeeff,
        128'h3243f6a8885a308d313198a2e0370734,
        128'h00000000000000000000000000000000
    };
    localparam aes_pkg::block_t KAT_CT [3] = '{
        128'h69c4e0d86a7b0430d8cdb78070b4c55a,
        128'h3925841d02dc09fbdc118597196a0b32,
        128'h66e94bd4ef8a2c3b884cfa59ca342b2e
    };

    logic            clk;
    logic            arst_n;
    logic            in_req;
    logic            in_ack;
    aes_pkg::block_t in_block;
    aes_pkg::block_t in_key;
    logic            out_req;
    logic            out_ack;
    aes_pkg::block_t out_block;

    int   cycle_cnt    = 0;
    int   err_count    = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;
    int   ack_cycle    = 0;   // cycle of the last in_ack rise
    int   req_cycle    = 0;   // cycle of the last out_req rise
    logic prev_in_ack  = 1'b0;
    logic prev_out_req = 1'b0;

    aes_encrypt i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_block  (in_block),
        .in_key    (in_key),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_block (out_block)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog
    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // edge recorder, also catches a capture before the output side is closed
    always @(negedge clk)
    begin
        if (in_ack && !prev_in_ack)
        begin
            ack_cycle = cycle_cnt;
            if (out_req || out_ack)
            begin
                $display("in_ack rose at %0t while the output handshake was open", $time);
                err_count++;
            end
        end
        if (out_req && !prev_out_req)
        begin
            req_cycle = cycle_cnt;
        end
        prev_in_ack  = in_ack;
        prev_out_req = out_req;
    end

    ////////////////////////////////////////
    // compare tasks

    task automatic check_block(input string name, input aes_pkg::block_t expected,
                               input aes_pkg::block_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %h got %h",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %b got %b",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("CHECK FAILED at %0t: %s expected %0d got %0d",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("test %s passed", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s failed with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////
    // handshake tasks

    task automatic raise_in_req(input aes_pkg::block_t blk, input aes_pkg::block_t key);
        @(posedge clk);
        in_block <= blk;
        in_key   <= key;
        in_req   <= 1'b1;
    endtask

    // wait for in_ack, hold in_req a few more cycles, then close the handshake
    task automatic release_in_req(input int hold);
        @(negedge clk);
        while (!in_ack)
        begin
            @(negedge clk);
        end
        repeat (hold) @(posedge clk);
        @(posedge clk);
        in_req <= 1'b0;
        @(negedge clk);
        while (in_ack)
        begin
            @(negedge clk);
        end
    endtask

    task automatic send_block(input aes_pkg::block_t blk, input aes_pkg::block_t key,
                              input int hold);
        raise_in_req(blk, key);
        release_in_req(hold);
    endtask

    // out_req and out_block must hold for as long as out_ack is withheld
    task automatic take_block(input aes_pkg::block_t expected, input int ack_delay);
        @(negedge clk);
        while (!out_req)
        begin
            @(negedge clk);
        end
        check_block("out_block", expected, out_block);
        for (int i = 0; i < ack_delay; i++)
        begin
            @(negedge clk);
            check_bit("out_req", 1'b1, out_req);
            check_block("out_block", expected, out_block);
        end
        @(posedge clk);
        out_ack <= 1'b1;
        @(negedge clk);
        check_bit("out_req", 1'b1, out_req);  // ack not seen until the next edge
        while (out_req)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        out_ack <= 1'b0;
    endtask

    ////////////////////////////////////////
    // tests

    task automatic reset_values();
        int errs;
        errs = err_count;
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(negedge clk);
            check_bit("in_ack", 1'b0, in_ack);
            check_bit("out_req", 1'b0, out_req);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        repeat (4)
        begin
            @(negedge clk);
            check_bit("in_ack", 1'b0, in_ack);
            check_bit("out_req", 1'b0, out_req);
        end
        report_test("reset_values", errs);
    endtask

    task automatic known_answers();
        int errs;
        errs = err_count;
        for (int i = 0; i < 3; i++)
        begin
            send_block(KAT_PT[i], KAT_KEY[i], 0);
            take_block(KAT_CT[i], 0);
        end
        report_test("known_answers", errs);
    endtask

    task automatic fixed_latency();
        int errs;
        int hold;
        errs = err_count;
        send_block(KAT_PT[1], KAT_KEY[1], 0);
        take_block(KAT_CT[1], 0);
        check_cycles("in_ack to out_req", LATENCY, req_cycle - ack_cycle);
        hold = 1 + int'($urandom % 8);
        send_block(KAT_PT[0], KAT_KEY[0], hold);
        take_block(KAT_CT[0], 0);
        check_cycles("in_ack to out_req", LATENCY, req_cycle - ack_cycle);
        report_test("fixed_latency", errs);
    endtask

    task automatic output_back_pressure();
        int errs;
        errs = err_count;
        send_block(KAT_PT[2], KAT_KEY[2], 0);
        take_block(KAT_CT[2], int'($urandom % 21));
        report_test("output_back_pressure", errs);
    endtask

    task automatic input_held_off();
        int errs;
        errs = err_count;
        send_block(KAT_PT[0], KAT_KEY[0], 0);
        @(negedge clk);
        while (!out_req)
        begin
            @(negedge clk);
        end
        raise_in_req(KAT_PT[1], KAT_KEY[1]);
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            check_bit("in_ack", 1'b0, in_ack);
            check_bit("out_req", 1'b1, out_req);
        end
        take_block(KAT_CT[0], int'($urandom % 8));
        @(negedge clk);
        check_bit("in_ack", 1'b0, in_ack);  // FSM still leaving OUT_RELEASE
        release_in_req(0);
        take_block(KAT_CT[1], 0);
        report_test("input_held_off", errs);
    endtask

    task automatic back_to_back();
        int errs;
        errs = err_count;
        for (int i = 0; i < 3; i++)
        begin
            repeat (int'($urandom % 8)) @(posedge clk);
            send_block(KAT_PT[i], KAT_KEY[i], int'($urandom % 8));
            take_block(KAT_CT[i], int'($urandom % 8));
        end
        report_test("back_to_back", errs);
    endtask

    initial
    begin
        arst_n   = 1'b0;
        in_req   = 1'b0;
        in_block = '0;
        in_key   = '0;
        out_ack  = 1'b0;
        void'($urandom(SEED));

        reset_values();
        known_answers();
        fixed_latency();
        output_back_pressure();
        input_held_off();
        back_to_back();

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_key_step.sv
verilog/aes_round.sv
verilog/aes_iter_ctrl.sv
verilog/aes_encrypt.sv
bench/tb_aes_encrypt.sv

/* run_sim.sh */
#!/bin/sh
# Builds the AES-128 core and its testbench with Verilator and runs it.
# Exits with a failing status unless the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_aes_encrypt -o tb_aes_encrypt \
    && ./obj_dir/tb_aes_encrypt | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
